// File: verilog.f
src/pic_cfg_pkg.sv
src/pic_seq_pkg.sv
src/pic_command_regs.sv
src/pic_ack_sequencer.sv
src/pic_service_ctrl.sv
src/pic_control.sv
verif/pic_control_props.sv
verif/tb_pic_control.sv

// File: verif/tb_pic_control.sv
`timescale 1ns/1ps

module tb_pic_control
  import pic_cfg_pkg::*;
();

  localparam int MAX_CYCLES = 400;

  typedef enum {WR_ICW1, WR_ICW24, WR_OCW1, WR_OCW2, WR_OCW3} write_kind_t;

  logic         clk = 1'b0;
  logic         rst;
  data_byte_t   data_bus;
  logic         write_icw1;
  logic         write_icw2to4;
  logic         write_ocw1;
  logic         write_ocw2;
  logic         write_ocw3;
  logic         inta;
  level_mask_t  irr_resolved;
  level_mask_t  in_service;
  level_mask_t  imr;
  logic         level_edge_triggered;
  read_sel_t    read_select;
  logic         int_req;
  level_mask_t  clear_irr;
  level_mask_t  end_of_interrupt;
  level_id_t    priority_rotate;
  logic         vector_enable;
  data_byte_t   vector_data;

  int           errors = 0;
  int           cycles = 0;
  int           seed = 18936;
  logic [31:0]  rand_word;
  vector_base_t vec_base;
  level_id_t    exp_rot;

  pic_control dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task check_mask(input string name, input level_mask_t expected, input level_mask_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task check_id(input string name, input level_id_t expected, input level_id_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
    end
  endtask

  task check_byte(input string name, input data_byte_t expected, input data_byte_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task check_sel(input string name, input read_sel_t expected, input read_sel_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %b, actual %b", $time, name, expected, actual);
    end
  endtask

  task check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %b, actual %b", $time, name, expected, actual);
    end
  endtask

  // Index of the lowest set bit or 7 for an empty mask
  function automatic level_id_t lowest_level(input level_mask_t mask);
    level_id_t idx;
    logic      found;
    idx = 3'd7;
    found = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (!found && mask[i]) begin
        idx = level_id_t'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  task next_in_service;
    rand_word = $random(seed);
    in_service = rand_word[7:0];
  endtask

  task bus_write(input write_kind_t kind, input data_byte_t value);
    @(negedge clk);
    data_bus = value;
    case (kind)
      WR_ICW1:  write_icw1 = 1'b1;
      WR_ICW24: write_icw2to4 = 1'b1;
      WR_OCW1:  write_ocw1 = 1'b1;
      WR_OCW2:  write_ocw2 = 1'b1;
      default:  write_ocw3 = 1'b1;
    endcase
    @(negedge clk);
    write_icw1 = 1'b0;
    write_icw2to4 = 1'b0;
    write_ocw1 = 1'b0;
    write_ocw2 = 1'b0;
    write_ocw3 = 1'b0;
  endtask

  // EOI mask shows only in the strobe cycle
  task ocw2_eoi(input data_byte_t value, input level_mask_t expected);
    @(negedge clk);
    data_bus = value;
    write_ocw2 = 1'b1;
    #1 check_mask("end_of_interrupt", expected, end_of_interrupt);
    @(negedge clk);
    write_ocw2 = 1'b0;
    #1 check_mask("end_of_interrupt", 8'h00, end_of_interrupt);
  endtask

  task inta_pulse(input int low_cycles, input logic second, input logic aeoi_on);
    @(negedge clk);
    check_bit("vector_enable", 1'b0, vector_enable);
    inta = 1'b0;
    repeat (low_cycles) begin
      @(negedge clk);
      check_bit("vector_enable", second, vector_enable);
      check_byte("vector_data", second ? {vec_base, lowest_level(in_service)} : 8'h00,
                 vector_data);
      check_mask("end_of_interrupt", 8'h00, end_of_interrupt);
      next_in_service;
    end
    inta = 1'b1;
    #1 check_bit("vector_enable", 1'b0, vector_enable);
    check_mask("end_of_interrupt", (second && aeoi_on) ? in_service : 8'h00, end_of_interrupt);
  endtask

  task inta_sequence(input logic aeoi_on);
    inta_pulse(2, 1'b0, aeoi_on);
    inta_pulse(3, 1'b1, aeoi_on);
    @(negedge clk);
    check_mask("end_of_interrupt", 8'h00, end_of_interrupt);
  endtask

  task reset_and_init;
    check_mask("imr", 8'hff, imr);
    check_sel("read_select", 2'b10, read_select);
    check_id("priority_rotate", 3'd7, priority_rotate);
    check_bit("int_req", 1'b0, int_req);
    bus_write(WR_ICW1, 8'h19);
    bus_write(WR_ICW24, 8'h40);
    bus_write(WR_OCW1, 8'h55);
    check_mask("imr", 8'hff, imr);
    bus_write(WR_ICW24, 8'h01);
    check_bit("level_edge_triggered", 1'b1, level_edge_triggered);
    bus_write(WR_OCW1, 8'h5a);
    bus_write(WR_OCW3, 8'h0b);
    check_mask("imr", 8'h5a, imr);
    check_sel("read_select", 2'b11, read_select);
    // Without IC4 the ICW2 write ends the sequence
    bus_write(WR_ICW1, 8'h10);
    check_mask("imr", 8'hff, imr);
    check_sel("read_select", 2'b10, read_select);
    check_bit("level_edge_triggered", 1'b0, level_edge_triggered);
    bus_write(WR_ICW24, 8'h48);
    vec_base = 5'b01001;
    bus_write(WR_OCW1, 8'h33);
    check_mask("imr", 8'h33, imr);
  endtask

  task ack_and_vector;
    @(negedge clk);
    irr_resolved = 8'h04;
    @(negedge clk);
    check_bit("int_req", 1'b1, int_req);
    irr_resolved = 8'h00;
    next_in_service;
    inta_sequence(1'b0);
    check_bit("int_req", 1'b0, int_req);
  endtask

  task eoi_commands;
    @(negedge clk);
    next_in_service;
    ocw2_eoi(8'h20, in_service);
    ocw2_eoi(8'h63, 8'h08);
    ocw2_eoi(8'he5, 8'h20);
    @(negedge clk);
    irr_resolved = 8'h12;
    data_bus = 8'h19;
    write_icw1 = 1'b1;
    #1 check_mask("end_of_interrupt", 8'hff, end_of_interrupt);
    check_mask("clear_irr", 8'hff, clear_irr);
    @(negedge clk);
    write_icw1 = 1'b0;
    #1 check_mask("clear_irr", 8'h12, clear_irr);
    check_mask("end_of_interrupt", 8'h00, end_of_interrupt);
    check_bit("int_req", 1'b0, int_req);
    @(negedge clk);
    irr_resolved = 8'h00;
    bus_write(WR_ICW24, 8'h48);
    bus_write(WR_ICW24, 8'h01);
  endtask

  task rotation;
    @(negedge clk);
    in_service = 8'h28;
    ocw2_eoi(8'ha0, 8'h28);
    check_id("priority_rotate", 3'd3, priority_rotate);
    bus_write(WR_OCW2, 8'h80);
    check_id("priority_rotate", 3'd3, priority_rotate);
    inta_sequence(1'b0);
    exp_rot = lowest_level(in_service);
    check_id("priority_rotate", exp_rot, priority_rotate);
    // Next sequence leaves rotation alone once auto rotation is off
    bus_write(WR_OCW2, 8'h00);
    inta_sequence(1'b0);
    check_id("priority_rotate", exp_rot, priority_rotate);
  endtask

  task auto_eoi;
    @(negedge clk);
    in_service = 8'h28;
    ocw2_eoi(8'ha0, 8'h28);
    check_id("priority_rotate", 3'd3, priority_rotate);
    bus_write(WR_ICW1, 8'h11);
    check_id("priority_rotate", 3'd7, priority_rotate);
    bus_write(WR_ICW24, 8'h70);
    vec_base = 5'b01110;
    bus_write(WR_ICW24, 8'h03);
    inta_sequence(1'b1);
  endtask

  initial begin
    rst = 1'b0;
    data_bus = 8'h00;
    write_icw1 = 1'b0;
    write_icw2to4 = 1'b0;
    write_ocw1 = 1'b0;
    write_ocw2 = 1'b0;
    write_ocw3 = 1'b0;
    inta = 1'b1;
    irr_resolved = 8'h00;
    in_service = 8'h00;
    vec_base = 5'b00000;
    repeat (2) @(negedge clk);
    rst = 1'b1;
    reset_and_init();
    ack_and_vector();
    eoi_commands();
    rotation();
    auto_eoi();
    repeat (2) @(negedge clk);
    $display("Errors: %0d, assertion failures: %0d", errors, dut.u_props.assert_failures);
    if (errors == 0 && dut.u_props.assert_failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verif/pic_control_props.sv
`timescale 1ns/1ps

module pic_control_props
  import pic_cfg_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        inta,
  input logic        write_icw1,
  input logic        int_req,
  input logic        vector_enable,
  input level_mask_t irr_resolved,
  input level_mask_t clear_irr,
  input level_mask_t end_of_interrupt
);

  int assert_failures = 0;

  // Vector byte only while INTA is held low
  a_vector_inta: assert property (@(posedge clk) disable iff (!rst)
    vector_enable |-> !inta) else begin
    assert_failures++;
    $error("vector_enable high while inta is high");
  end

  a_icw1_req: assert property (@(posedge clk) disable iff (!rst)
    write_icw1 |=> !int_req) else begin
    assert_failures++;
    $error("int_req not cleared after ICW1 write");
  end

  a_icw1_eoi: assert property (@(posedge clk) disable iff (!rst)
    write_icw1 |-> (end_of_interrupt == 8'hff)) else begin
    assert_failures++;
    $error("end_of_interrupt not all ones during ICW1 write");
  end

  // Pass-through of the resolved requests
  a_clear_irr: assert property (@(posedge clk) disable iff (!rst)
    !write_icw1 |-> (clear_irr == irr_resolved)) else begin
    assert_failures++;
    $error("clear_irr differs from irr_resolved");
  end

endmodule

bind pic_control pic_control_props u_props (.*);

// File: src/pic_control.sv
`timescale 1ns/1ps

module pic_control
  import pic_cfg_pkg::*;
  import pic_seq_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  data_byte_t  data_bus,
  input  logic        write_icw1,
  input  logic        write_icw2to4,
  input  logic        write_ocw1,
  input  logic        write_ocw2,
  input  logic        write_ocw3,
  input  logic        inta,
  input  level_mask_t irr_resolved,
  input  level_mask_t in_service,
  output level_mask_t imr,
  output logic        level_edge_triggered,
  output read_sel_t   read_select,
  output logic        int_req,
  output level_mask_t clear_irr,
  output level_mask_t end_of_interrupt,
  output level_id_t   priority_rotate,
  output logic        vector_enable,
  output data_byte_t  vector_data
);

  pic_config_t cfg;
  ocw2_cmd_t   ocw2_cmd;
  ack_status_t ack;

  pic_command_regs u_command_regs (
    .clk           (clk),
    .rst           (rst),
    .data_bus      (data_bus),
    .write_icw1    (write_icw1),
    .write_icw2to4 (write_icw2to4),
    .write_ocw1    (write_ocw1),
    .write_ocw2    (write_ocw2),
    .write_ocw3    (write_ocw3),
    .cfg           (cfg),
    .ocw2_cmd      (ocw2_cmd)
  );

  pic_ack_sequencer u_ack_sequencer (
    .clk          (clk),
    .rst          (rst),
    .inta         (inta),
    .write_icw1   (write_icw1),
    .irr_resolved (irr_resolved),
    .ack          (ack),
    .int_req      (int_req),
    .clear_irr    (clear_irr)
  );

  pic_service_ctrl u_service_ctrl (
    .clk              (clk),
    .rst              (rst),
    .write_icw1       (write_icw1),
    .cfg              (cfg),
    .ocw2_cmd         (ocw2_cmd),
    .ack              (ack),
    .in_service       (in_service),
    .end_of_interrupt (end_of_interrupt),
    .priority_rotate  (priority_rotate),
    .vector_enable    (vector_enable),
    .vector_data      (vector_data)
  );

  assign imr = cfg.imr;
  assign level_edge_triggered = cfg.level_edge;
  assign read_select = cfg.read_select;

endmodule

// File: src/pic_service_ctrl.sv
`timescale 1ns/1ps

module pic_service_ctrl
  import pic_cfg_pkg::*;
  import pic_seq_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        write_icw1,
  input  pic_config_t cfg,
  input  ocw2_cmd_t   ocw2_cmd,
  input  ack_status_t ack,
  input  level_mask_t in_service,
  output level_mask_t end_of_interrupt,
  output level_id_t   priority_rotate,
  output logic        vector_enable,
  output data_byte_t  vector_data
);

  level_id_t isr_lowest;
  logic      nonspec_eoi;

  // Lowest set bit of in_service, 7 when empty
  always_comb begin
    isr_lowest = ROTATE_RESET;
    for (int i = 7; i >= 0; i--) begin
      if (in_service[i]) begin
        isr_lowest = level_id_t'(i);
      end
    end
  end

  assign nonspec_eoi = (ocw2_cmd.op == OP_EOI_NONSPEC) ||
                       (ocw2_cmd.op == OP_ROTATE_EOI_NONSPEC);

  always_comb begin
    if (write_icw1) begin
      end_of_interrupt = '1;
    end else if (cfg.aeoi && ack.end_of_ack) begin
      end_of_interrupt = in_service;
    end else if (nonspec_eoi) begin
      end_of_interrupt = in_service;
    end else if (ocw2_cmd.op == OP_EOI_SPEC) begin
      end_of_interrupt = level_mask_t'(1) << ocw2_cmd.level;
    end else begin
      end_of_interrupt = '0;
    end
  end

  // Rotation point follows the level just serviced
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      priority_rotate <= ROTATE_RESET;
    end else if (write_icw1) begin
      priority_rotate <= ROTATE_RESET;
    end else if (cfg.auto_rotate && ack.end_of_ack) begin
      priority_rotate <= isr_lowest;
    end else if (ocw2_cmd.op == OP_ROTATE_EOI_NONSPEC) begin
      priority_rotate <= isr_lowest;
    end
  end

  assign vector_enable = ack.vector_window;

  always_comb begin
    if (vector_enable) begin
      vector_data = {cfg.vector_base, isr_lowest};
    end else begin
      vector_data = '0;
    end
  end

endmodule

// File: src/pic_ack_sequencer.sv
`timescale 1ns/1ps

module pic_ack_sequencer
  import pic_cfg_pkg::*;
  import pic_seq_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        inta,
  input  logic        write_icw1,
  input  level_mask_t irr_resolved,
  output ack_status_t ack,
  output logic        int_req,
  output level_mask_t clear_irr
);

  ack_state_t state;
  ack_state_t state_next;
  logic       inta_d;
  logic       inta_fall;
  logic       inta_rise;

  // INTA idles high
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      inta_d <= 1'b1;
    end else begin
      inta_d <= inta;
    end
  end

  assign inta_fall = inta_d && !inta;
  assign inta_rise = !inta_d && inta;

  always_comb begin
    state_next = state;
    case (state)
      ACK_IDLE:   if (inta_fall) state_next = ACK_FIRST;
      ACK_FIRST:  if (inta_fall) state_next = ACK_SECOND;
      ACK_SECOND: if (inta_rise) state_next = ACK_IDLE;
      default:    state_next = ACK_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= ACK_IDLE;
    end else if (write_icw1) begin
      state <= ACK_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Sequence ends when INTA rises out of the second pulse
  assign ack.end_of_ack = (state == ACK_SECOND) && inta_rise;
  assign ack.vector_window = (state == ACK_SECOND) && !inta;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      int_req <= 1'b0;
    end else if (write_icw1) begin
      int_req <= 1'b0;
    end else if (irr_resolved != '0) begin
      int_req <= 1'b1;
    end else if (ack.end_of_ack) begin
      int_req <= 1'b0;
    end
  end

  // Clears the whole IRR on ICW1
  assign clear_irr = write_icw1 ? '1 : irr_resolved;

endmodule

// File: src/pic_command_regs.sv
`timescale 1ns/1ps

module pic_command_regs
  import pic_cfg_pkg::*;
  import pic_seq_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  data_byte_t  data_bus,
  input  logic        write_icw1,
  input  logic        write_icw2to4,
  input  logic        write_ocw1,
  input  logic        write_ocw2,
  input  logic        write_ocw3,
  output pic_config_t cfg,
  output ocw2_cmd_t   ocw2_cmd
);

  init_state_t init_state;
  init_state_t init_next;
  logic        ic4;
  logic        write_icw2;
  logic        write_icw4;
  logic        ocw_enable;
  logic        ocw2_write;
  logic [2:0]  ocw2_op_field;

  // ICW2/ICW4 share one strobe, the sequencer tells them apart
  assign write_icw2 = write_icw2to4 && (init_state == INIT_ICW2);
  assign write_icw4 = write_icw2to4 && (init_state == INIT_ICW4);
  assign ocw_enable = (init_state == INIT_IDLE);
  assign ocw2_write = write_ocw2 && ocw_enable;
  assign ocw2_op_field = data_bus[OCW2_OP_MSB:OCW2_OP_LSB];

  always_comb begin
    init_next = init_state;
    if (write_icw1) begin
      init_next = INIT_ICW2;
    end else if (write_icw2to4) begin
      case (init_state)
        INIT_ICW2: init_next = ic4 ? INIT_ICW4 : INIT_IDLE;
        INIT_ICW4: init_next = INIT_IDLE;
        default:   init_next = init_state;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      init_state <= INIT_IDLE;
    end else begin
      init_state <= init_next;
    end
  end

  // ICW1 trigger mode and IC4
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cfg.level_edge <= 1'b0;
      ic4 <= 1'b0;
    end else if (write_icw1) begin
      cfg.level_edge <= data_bus[ICW1_LTIM_BIT];
      ic4 <= data_bus[ICW1_IC4_BIT];
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cfg.vector_base <= '0;
      cfg.aeoi <= 1'b0;
    end else if (write_icw1) begin
      cfg.vector_base <= '0;
      cfg.aeoi <= 1'b0;
    end else begin
      if (write_icw2) begin
        cfg.vector_base <= data_bus[7:VECTOR_BASE_LSB];
      end
      if (write_icw4) begin
        cfg.aeoi <= data_bus[ICW4_AEOI_BIT];
      end
    end
  end

  // OCW1 mask, OCW3 read select, OCW2 rotate mode
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cfg.imr <= IMR_RESET;
      cfg.read_select <= READ_SEL_RESET;
      cfg.auto_rotate <= 1'b0;
    end else if (write_icw1) begin
      cfg.imr <= IMR_RESET;
      cfg.read_select <= READ_SEL_RESET;
      cfg.auto_rotate <= 1'b0;
    end else begin
      if (write_ocw1 && ocw_enable) begin
        cfg.imr <= data_bus;
      end
      if (write_ocw3 && ocw_enable) begin
        cfg.read_select <= data_bus[1:0];
      end
      if (ocw2_write && (ocw2_op_field == 3'b100)) begin
        cfg.auto_rotate <= 1'b1;
      end else if (ocw2_write && (ocw2_op_field == 3'b000)) begin
        cfg.auto_rotate <= 1'b0;
      end
    end
  end

  always_comb begin
    ocw2_cmd.op = OP_NONE;
    ocw2_cmd.level = '0;
    if (ocw2_write) begin
      ocw2_cmd.level = data_bus[2:0];
      case (ocw2_op_field)
        3'b001:         ocw2_cmd.op = OP_EOI_NONSPEC;
        3'b011, 3'b111: ocw2_cmd.op = OP_EOI_SPEC;
        3'b101:         ocw2_cmd.op = OP_ROTATE_EOI_NONSPEC;
        default:        ocw2_cmd.op = OP_NONE;
      endcase
    end
  end

endmodule

// File: src/pic_seq_pkg.sv
package pic_seq_pkg;

  import pic_cfg_pkg::*;

  typedef enum logic [1:0] {
    INIT_IDLE,
    INIT_ICW2,
    INIT_ICW4
  } init_state_t;

  typedef enum logic [1:0] {
    ACK_IDLE,
    ACK_FIRST,
    ACK_SECOND
  } ack_state_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_EOI_NONSPEC,
    OP_EOI_SPEC,
    OP_ROTATE_EOI_NONSPEC
  } ocw2_op_t;

  // One-cycle EOI command decoded from an OCW2 write
  typedef struct packed {
    ocw2_op_t op;
    level_id_t level;
  } ocw2_cmd_t;

  typedef struct packed {
    logic end_of_ack;
    logic vector_window;
  } ack_status_t;

endpackage

// File: src/pic_cfg_pkg.sv
package pic_cfg_pkg;

  // Widths with a meaning of their own
  typedef logic [7:0] data_byte_t;
  typedef logic [7:0] level_mask_t;
  typedef logic [2:0] level_id_t;
  typedef logic [4:0] vector_base_t;
  typedef logic [1:0] read_sel_t;

  // ICW1 fields
  localparam int ICW1_LTIM_BIT = 3;
  localparam int ICW1_IC4_BIT = 0;

  // ICW4 fields
  localparam int ICW4_AEOI_BIT = 1;

  // OCW2 command field R, SL, EOI
  localparam int OCW2_OP_MSB = 7;
  localparam int OCW2_OP_LSB = 5;

  // Vector byte is base[7:3] and level[2:0]
  localparam int VECTOR_BASE_LSB = 3;

  localparam level_mask_t IMR_RESET = 8'hff;
  localparam read_sel_t READ_SEL_RESET = 2'b10;
  localparam level_id_t ROTATE_RESET = 3'd7;

  // Programmed configuration, 18 bits
  typedef struct packed {
    logic level_edge;
    logic aeoi;
    logic auto_rotate;
    vector_base_t vector_base;
    level_mask_t imr;
    read_sel_t read_select;
  } pic_config_t;

endpackage
